// ==== source/sa_pkg.sv ====
package sa_pkg;

    // array geometry.
    localparam int HEIGHT = 4;
    localparam int WIDTH  = 4;

    // input and weight width.
    localparam int IWIDTH = 4;

    // accumulator width. worst case sum is 15 * 15 * 4 = 900.
    localparam int OWIDTH = 12;

    // unary window, one cycle per input code.
    localparam int WINDOW = 2 ** IWIDTH;

    // start_i sampled to done_o high.
    localparam int LATENCY = WINDOW + WIDTH + HEIGHT + 1;

    // sequencer counter.
    localparam int CNT_WIDTH = $clog2(WINDOW + WIDTH);

    typedef logic [CNT_WIDTH-1:0] cnt_t;

    // compute phase: window, mac_done, then skew of the last column.
    localparam cnt_t WIN_CNT      = cnt_t'(WINDOW);
    localparam cnt_t COMPUTE_LAST = cnt_t'(WINDOW + WIDTH - 1);
    localparam cnt_t DRAIN_CNT    = cnt_t'(HEIGHT);

    typedef logic [OWIDTH-1:0] acc_t;

    typedef logic [HEIGHT-1:0][IWIDTH-1:0] ifm_vec_t;
    typedef logic [WIDTH-1:0][IWIDTH-1:0]  wght_row_t;
    typedef logic [WIDTH-1:0][OWIDTH-1:0]  ofm_vec_t;

    // strobes that move between elements together.
    typedef struct packed {
        logic en;
        logic clr;
        logic done;
    } pe_ctl_t;

    typedef enum logic [1:0] {
        PH_IDLE,
        PH_COMPUTE,
        PH_DRAIN
    } phase_t;

endpackage

// ==== source/pe_border.sv ====
`timescale 1ns/10ps

module pe_border (
    input  logic                      clk,
    input  logic                      rst_i,
    input  sa_pkg::pe_ctl_t           row_ctl_i,
    input  logic [sa_pkg::IWIDTH-1:0] ifm_i,
    input  logic                      en_w_i,
    input  logic [sa_pkg::IWIDTH-1:0] wght_i,
    input  logic [sa_pkg::OWIDTH-1:0] sum_i,
    input  sa_pkg::pe_ctl_t           drain_ctl_i,
    output sa_pkg::pe_ctl_t           row_ctl_o,
    output logic                      ifm_bit_o,
    output logic                      en_w_o,
    output logic [sa_pkg::IWIDTH-1:0] wght_o,
    output logic [sa_pkg::OWIDTH-1:0] sum_o,
    output sa_pkg::pe_ctl_t           drain_ctl_o
);

    logic [sa_pkg::IWIDTH-1:0] ifm_q;
    logic [sa_pkg::IWIDTH-1:0] ifm_cur;
    logic [sa_pkg::IWIDTH-1:0] win_q;
    logic [sa_pkg::IWIDTH-1:0] win_cur;
    logic                      bit_now;

    logic [sa_pkg::IWIDTH-1:0] w_q;
    logic [sa_pkg::OWIDTH-1:0] acc_q;
    sa_pkg::acc_t              acc_base;
    sa_pkg::acc_t              addend;

    // first window cycle takes the fresh value and a zero count.
    assign ifm_cur = row_ctl_i.clr ? ifm_i : ifm_q;
    assign win_cur = row_ctl_i.clr ? '0 : win_q;

    // thermometer code, high for the first ifm cycles.
    assign bit_now = row_ctl_i.en && (win_cur < ifm_cur);

    assign acc_base = row_ctl_i.clr ? '0 : acc_q;
    assign addend   = bit_now ? sa_pkg::acc_t'(w_q) : '0;

    // weights shift down the column on a common enable.
    assign en_w_o = en_w_i;
    assign wght_o = w_q;

    always_ff @(posedge clk) begin
        if (row_ctl_i.en) begin
            ifm_q <= ifm_cur;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            win_q <= '0;
        end else if (row_ctl_i.done) begin
            win_q <= '0;
        end else if (row_ctl_i.en) begin
            win_q <= win_cur + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            w_q         <= '0;
            acc_q       <= '0;
            sum_o       <= '0;
            row_ctl_o   <= '0;
            ifm_bit_o   <= 1'b0;
            drain_ctl_o <= '0;
        end else begin
            if (en_w_i) begin
                w_q <= wght_i;
            end
            if (row_ctl_i.en) begin
                acc_q <= acc_base + addend;
            end
            // partial sum from below plus own product.
            if (drain_ctl_i.clr) begin
                sum_o <= '0;
            end else if (drain_ctl_i.en) begin
                sum_o <= acc_q + sum_i;
            end
            row_ctl_o   <= row_ctl_i;
            ifm_bit_o   <= bit_now;
            drain_ctl_o <= drain_ctl_i;
        end
    end

endmodule

// ==== source/pe_inner.sv ====
`timescale 1ns/10ps

module pe_inner (
    input  logic                      clk,
    input  logic                      rst_i,
    input  sa_pkg::pe_ctl_t           row_ctl_i,
    input  logic                      ifm_bit_i,
    input  logic                      en_w_i,
    input  logic [sa_pkg::IWIDTH-1:0] wght_i,
    input  logic [sa_pkg::OWIDTH-1:0] sum_i,
    input  sa_pkg::pe_ctl_t           drain_ctl_i,
    output sa_pkg::pe_ctl_t           row_ctl_o,
    output logic                      ifm_bit_o,
    output logic                      en_w_o,
    output logic [sa_pkg::IWIDTH-1:0] wght_o,
    output logic [sa_pkg::OWIDTH-1:0] sum_o,
    output sa_pkg::pe_ctl_t           drain_ctl_o
);

    logic [sa_pkg::IWIDTH-1:0] w_q;
    logic [sa_pkg::OWIDTH-1:0] acc_q;
    sa_pkg::acc_t              acc_base;
    sa_pkg::acc_t              addend;

    assign acc_base = row_ctl_i.clr ? '0 : acc_q;

    // one unary bit adds the weight once.
    assign addend = ifm_bit_i ? sa_pkg::acc_t'(w_q) : '0;

    assign en_w_o = en_w_i;
    assign wght_o = w_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            w_q         <= '0;
            acc_q       <= '0;
            sum_o       <= '0;
            row_ctl_o   <= '0;
            ifm_bit_o   <= 1'b0;
            drain_ctl_o <= '0;
        end else begin
            if (en_w_i) begin
                w_q <= wght_i;
            end
            if (row_ctl_i.en) begin
                acc_q <= acc_base + addend;
            end
            if (drain_ctl_i.clr) begin
                sum_o <= '0;
            end else if (drain_ctl_i.en) begin
                sum_o <= acc_q + sum_i;
            end
            // skew to the next column.
            row_ctl_o   <= row_ctl_i;
            ifm_bit_o   <= ifm_bit_i;
            drain_ctl_o <= drain_ctl_i;
        end
    end

endmodule

// ==== source/array_4.sv ====
`timescale 1ns/10ps

module array_4 (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  sa_pkg::pe_ctl_t [sa_pkg::HEIGHT-1:0]  row_ctl_i,
    input  logic [sa_pkg::WIDTH-1:0]              en_w_i,
    input  sa_pkg::wght_row_t                     wght_i,
    input  sa_pkg::pe_ctl_t [sa_pkg::WIDTH-1:0]   col_ctl_i,
    input  sa_pkg::ifm_vec_t                      ifm_i,
    output sa_pkg::ofm_vec_t                      ofm_o
);

    // row direction, [row][column boundary].
    sa_pkg::pe_ctl_t row_x [sa_pkg::HEIGHT-1:0][sa_pkg::WIDTH:0];
    logic            bit_x [sa_pkg::HEIGHT-1:0][sa_pkg::WIDTH:1];

    // column direction, [column][row boundary].
    logic                      en_w_x  [sa_pkg::WIDTH-1:0][sa_pkg::HEIGHT:0];
    logic [sa_pkg::IWIDTH-1:0] wght_x  [sa_pkg::WIDTH-1:0][sa_pkg::HEIGHT:0];
    logic [sa_pkg::OWIDTH-1:0] sum_x   [sa_pkg::WIDTH-1:0][sa_pkg::HEIGHT:0];
    sa_pkg::pe_ctl_t           drain_x [sa_pkg::WIDTH-1:0][sa_pkg::HEIGHT:0];

    for (genvar h = 0; h < sa_pkg::HEIGHT; h++) begin : g_row_in
        assign row_x[h][0] = row_ctl_i[h];
    end

    for (genvar w = 0; w < sa_pkg::WIDTH; w++) begin : g_col_io
        assign en_w_x[w][0]             = en_w_i[w];
        assign wght_x[w][0]             = wght_i[w];
        // drain enters at the bottom with nothing below it.
        assign drain_x[w][sa_pkg::HEIGHT] = col_ctl_i[w];
        assign sum_x[w][sa_pkg::HEIGHT]   = '0;
        assign ofm_o[w]                   = sum_x[w][0];
    end

    for (genvar h = 0; h < sa_pkg::HEIGHT; h++) begin : g_row
        pe_border u_border (
            .clk         (clk),
            .rst_i       (rst_i),
            .row_ctl_i   (row_x[h][0]),
            .ifm_i       (ifm_i[h]),
            .en_w_i      (en_w_x[0][h]),
            .wght_i      (wght_x[0][h]),
            .sum_i       (sum_x[0][h+1]),
            .drain_ctl_i (drain_x[0][h+1]),
            .row_ctl_o   (row_x[h][1]),
            .ifm_bit_o   (bit_x[h][1]),
            .en_w_o      (en_w_x[0][h+1]),
            .wght_o      (wght_x[0][h+1]),
            .sum_o       (sum_x[0][h]),
            .drain_ctl_o (drain_x[0][h])
        );

        for (genvar w = 1; w < sa_pkg::WIDTH; w++) begin : g_col
            pe_inner u_inner (
                .clk         (clk),
                .rst_i       (rst_i),
                .row_ctl_i   (row_x[h][w]),
                .ifm_bit_i   (bit_x[h][w]),
                .en_w_i      (en_w_x[w][h]),
                .wght_i      (wght_x[w][h]),
                .sum_i       (sum_x[w][h+1]),
                .drain_ctl_i (drain_x[w][h+1]),
                .row_ctl_o   (row_x[h][w+1]),
                .ifm_bit_o   (bit_x[h][w+1]),
                .en_w_o      (en_w_x[w][h+1]),
                .wght_o      (wght_x[w][h+1]),
                .sum_o       (sum_x[w][h]),
                .drain_ctl_o (drain_x[w][h])
            );
        end
    end

endmodule

// ==== source/array_ctrl.sv ====
`timescale 1ns/10ps

module array_ctrl (
    input  logic                                  clk,
    input  logic                                  rst_i,
    input  logic                                  wght_valid_i,
    input  logic                                  start_i,
    input  sa_pkg::ifm_vec_t                      ifm_i,
    output sa_pkg::pe_ctl_t [sa_pkg::HEIGHT-1:0]  row_ctl_o,
    output logic [sa_pkg::WIDTH-1:0]              en_w_o,
    output sa_pkg::pe_ctl_t [sa_pkg::WIDTH-1:0]   col_ctl_o,
    output sa_pkg::ifm_vec_t                      ifm_o,
    output logic                                  busy_o,
    output logic                                  done_o
);

    sa_pkg::phase_t  state_q;
    sa_pkg::cnt_t    cnt_q;
    sa_pkg::pe_ctl_t row_ctl;
    sa_pkg::pe_ctl_t col_ctl;
    logic            idle;

    assign idle   = (state_q == sa_pkg::PH_IDLE);
    assign busy_o = !idle;

    // weights only move while the array is idle.
    assign en_w_o = {sa_pkg::WIDTH{wght_valid_i && idle}};

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= sa_pkg::PH_IDLE;
            cnt_q   <= '0;
            done_o  <= 1'b0;
        end else begin
            done_o <= 1'b0;
            case (state_q)
                sa_pkg::PH_IDLE: begin
                    if (start_i) begin
                        state_q <= sa_pkg::PH_COMPUTE;
                        cnt_q   <= '0;
                    end
                end
                sa_pkg::PH_COMPUTE: begin
                    // window, mac_done and the column skew.
                    if (cnt_q == sa_pkg::COMPUTE_LAST) begin
                        state_q <= sa_pkg::PH_DRAIN;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                sa_pkg::PH_DRAIN: begin
                    // one extra cycle for the top sum to settle.
                    if (cnt_q == sa_pkg::DRAIN_CNT) begin
                        state_q <= sa_pkg::PH_IDLE;
                        cnt_q   <= '0;
                        done_o  <= 1'b1;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= sa_pkg::PH_IDLE;
                end
            endcase
        end
    end

    // input vector held for the whole window.
    always_ff @(posedge clk) begin
        if (idle && start_i) begin
            ifm_o <= ifm_i;
        end
    end

    always_comb begin
        row_ctl = '0;
        col_ctl = '0;
        if (state_q == sa_pkg::PH_COMPUTE) begin
            row_ctl.en   = (cnt_q < sa_pkg::WIN_CNT);
            row_ctl.clr  = (cnt_q == '0);
            row_ctl.done = (cnt_q == sa_pkg::WIN_CNT);
        end
        if (state_q == sa_pkg::PH_DRAIN) begin
            col_ctl.en   = (cnt_q < sa_pkg::DRAIN_CNT);
            col_ctl.clr  = (cnt_q == '0);
        end
    end

    // all rows start together and all columns drain together.
    assign row_ctl_o = {sa_pkg::HEIGHT{row_ctl}};
    assign col_ctl_o = {sa_pkg::WIDTH{col_ctl}};

endmodule

// ==== source/sa_top.sv ====
`timescale 1ns/10ps

module sa_top (
    input  logic              clk,
    input  logic              rst_i,
    input  logic              wght_valid_i,
    input  sa_pkg::wght_row_t wght_i,
    input  logic              start_i,
    input  sa_pkg::ifm_vec_t  ifm_i,
    output logic              busy_o,
    output logic              done_o,
    output sa_pkg::ofm_vec_t  ofm_o
);

    sa_pkg::pe_ctl_t [sa_pkg::HEIGHT-1:0] row_ctl;
    sa_pkg::pe_ctl_t [sa_pkg::WIDTH-1:0]  col_ctl;
    logic [sa_pkg::WIDTH-1:0]             en_w;
    sa_pkg::ifm_vec_t                     ifm_q;

    array_ctrl u_ctrl (
        .clk          (clk),
        .rst_i        (rst_i),
        .wght_valid_i (wght_valid_i),
        .start_i      (start_i),
        .ifm_i        (ifm_i),
        .row_ctl_o    (row_ctl),
        .en_w_o       (en_w),
        .col_ctl_o    (col_ctl),
        .ifm_o        (ifm_q),
        .busy_o       (busy_o),
        .done_o       (done_o)
    );

    array_4 u_array (
        .clk       (clk),
        .rst_i     (rst_i),
        .row_ctl_i (row_ctl),
        .en_w_i    (en_w),
        .wght_i    (wght_i),
        .col_ctl_i (col_ctl),
        .ifm_i     (ifm_q),
        .ofm_o     (ofm_o)
    );

endmodule

// ==== tb/sa_assertions.sv ====
`timescale 1ns/10ps

module sa_assertions (
    input logic clk,
    input logic rst_i,
    input logic start_i,
    input logic busy_o,
    input logic done_o
);

    int fail_cnt = 0;

    // done is a single-cycle pulse.
    a_done_pulse: assert property (@(posedge clk) disable iff (rst_i) done_o |=> !done_o)
    else begin
        fail_cnt++;
        $error("done_o held for more than one cycle");
    end

    a_busy_fall: assert property (@(posedge clk) disable iff (rst_i) $fell(busy_o) |-> done_o)
    else begin
        fail_cnt++;
        $error("busy_o fell without done_o");
    end

    a_reset_idle: assert property (@(posedge clk) rst_i |=> (!done_o && !busy_o))
    else begin
        fail_cnt++;
        $error("busy_o or done_o high after reset");
    end

    // an ignored start must not push done_o out.
    a_no_restart: assert property (@(posedge clk) disable iff (rst_i)
        (start_i && !busy_o) |-> ##(sa_pkg::LATENCY + 1) done_o)
    else begin
        fail_cnt++;
        $error("done_o missing LATENCY cycles after an accepted start_i");
    end

endmodule

bind sa_top sa_assertions u_sva (.*);

// ==== tb/sa_tb.sv ====
`timescale 1ns/10ps

module sa_tb;

    // runs over all tests, used to size the timeout.
    localparam int RUNS = 15;
    localparam int TIMEOUT_CYCLES = RUNS * (sa_pkg::LATENCY + sa_pkg::HEIGHT + 10) + 200;

    logic              clk;
    logic              rst_i;
    logic              wght_valid_i;
    sa_pkg::wght_row_t wght_i;
    logic              start_i;
    sa_pkg::ifm_vec_t  ifm_i;
    logic              busy_o;
    logic              done_o;
    sa_pkg::ofm_vec_t  ofm_o;

    // reference weights, wmat[h][w] for row h and column w.
    sa_pkg::wght_row_t wmat [sa_pkg::HEIGHT];

    int     errors;
    int     cycle_cnt;
    integer seed;

    sa_top dut (
        .clk          (clk),
        .rst_i        (rst_i),
        .wght_valid_i (wght_valid_i),
        .wght_i       (wght_i),
        .start_i      (start_i),
        .ifm_i        (ifm_i),
        .busy_o       (busy_o),
        .done_o       (done_o),
        .ofm_o        (ofm_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    function automatic sa_pkg::ofm_vec_t expected_ofm(input sa_pkg::ifm_vec_t v);
        sa_pkg::ofm_vec_t r;
        int               acc;
        for (int w = 0; w < sa_pkg::WIDTH; w++) begin
            acc = 0;
            for (int h = 0; h < sa_pkg::HEIGHT; h++) begin
                acc += int'(v[h]) * int'(wmat[h][w]);
            end
            r[w] = acc[sa_pkg::OWIDTH-1:0];
        end
        return r;
    endfunction

    function automatic sa_pkg::ifm_vec_t random_ifm();
        sa_pkg::ifm_vec_t v;
        for (int h = 0; h < sa_pkg::HEIGHT; h++) begin
            v[h] = 4'($random(seed));
        end
        return v;
    endfunction

    task automatic check_ofm(input string name, input sa_pkg::ofm_vec_t got,
                             input sa_pkg::ofm_vec_t exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("error %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("error done_o latency got %h expected %h", got, exp);
            errors++;
        end
    endtask

    // bottom row goes in first and ends up in the last row.
    task automatic load_weights();
        for (int k = 0; k < sa_pkg::HEIGHT; k++) begin
            @(posedge clk);
            wght_valid_i <= 1'b1;
            wght_i       <= wmat[sa_pkg::HEIGHT-1-k];
        end
        @(posedge clk);
        wght_valid_i <= 1'b0;
        wght_i       <= '0;
    endtask

    task automatic random_weights();
        for (int h = 0; h < sa_pkg::HEIGHT; h++) begin
            for (int w = 0; w < sa_pkg::WIDTH; w++) begin
                wmat[h][w] = 4'($random(seed));
            end
        end
    endtask

    // disturb pokes a start and a weight load in while busy.
    task automatic run_vector(input sa_pkg::ifm_vec_t v, input logic disturb);
        sa_pkg::ofm_vec_t exp_ofm;
        int               lat;
        exp_ofm = expected_ofm(v);
        @(posedge clk);
        start_i <= 1'b1;
        ifm_i   <= v;
        @(posedge clk);
        start_i <= 1'b0;
        ifm_i   <= ~v;
        lat = 0;
        @(negedge clk);
        check_bit("busy_o", busy_o, 1'b1);
        while (!done_o && lat <= sa_pkg::LATENCY + 10) begin
            @(posedge clk);
            lat++;
            if (disturb && lat == 5) begin
                start_i      <= 1'b1;
                ifm_i        <= random_ifm();
                wght_valid_i <= 1'b1;
                wght_i       <= 16'($random(seed));
            end else if (disturb && lat == 6) begin
                start_i      <= 1'b0;
                wght_valid_i <= 1'b0;
            end
            @(negedge clk);
        end
        if (!done_o) begin
            $display("done_o never came after start_i");
            errors++;
        end else begin
            check_latency(lat, sa_pkg::LATENCY);
            check_bit("busy_o", busy_o, 1'b0);
            check_ofm("ofm_o", ofm_o, exp_ofm);
        end
    endtask

    task automatic idle_after_reset();
        @(negedge clk);
        check_bit("busy_o", busy_o, 1'b0);
        check_bit("done_o", done_o, 1'b0);
        for (int h = 0; h < sa_pkg::HEIGHT; h++) begin
            wmat[h] = '0;
        end
        run_vector(random_ifm(), 1'b0);
    endtask

    task automatic identity_weights();
        for (int h = 0; h < sa_pkg::HEIGHT; h++) begin
            for (int w = 0; w < sa_pkg::WIDTH; w++) begin
                wmat[h][w] = (h == w) ? 4'd1 : 4'd0;
            end
        end
        load_weights();
        run_vector({4'd9, 4'd15, 4'd0, 4'd6}, 1'b0);
    endtask

    task automatic full_scale();
        for (int h = 0; h < sa_pkg::HEIGHT; h++) begin
            wmat[h] = '1;
        end
        load_weights();
        run_vector('1, 1'b0);
    endtask

    task automatic random_runs();
        sa_pkg::ifm_vec_t v;
        for (int r = 0; r < 8; r++) begin
            random_weights();
            v = random_ifm();
            // force some zero codes in.
            if (r == 3) begin
                v[1]    = '0;
                wmat[2] = '0;
            end
            load_weights();
            run_vector(v, 1'b0);
        end
    endtask

    task automatic busy_ignored();
        random_weights();
        load_weights();
        run_vector(random_ifm(), 1'b1);
        // old weights must still be in place.
        run_vector(random_ifm(), 1'b0);
    endtask

    task automatic back_to_back();
        random_weights();
        load_weights();
        run_vector('1, 1'b0);
        run_vector({4'd1, 4'd0, 4'd2, 4'd1}, 1'b0);
    endtask

    initial begin
        errors       = 0;
        cycle_cnt    = 0;
        seed         = 32'hb251;
        rst_i        = 1'b1;
        wght_valid_i = 1'b0;
        wght_i       = '0;
        start_i      = 1'b0;
        ifm_i        = '0;
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;

        idle_after_reset();
        identity_weights();
        full_scale();
        random_runs();
        busy_ignored();
        back_to_back();

        repeat (2) @(posedge clk);
        $display("check errors: %0d, assertion errors: %0d", errors, dut.u_sva.fail_cnt);
        if (errors == 0 && dut.u_sva.fail_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== build.f ====
source/sa_pkg.sv
source/pe_border.sv
source/pe_inner.sv
source/array_4.sv
source/array_ctrl.sv
source/sa_top.sv
tb/sa_assertions.sv
tb/sa_tb.sv
